// File: sim.f
+incdir+verification
hdl/mem_pkg.sv
hdl/mem_region_cfg.sv
hdl/store_align.sv
hdl/load_extract.sv
hdl/data_ram.sv
hdl/data_memory_wrapper.sv
hdl/memory.sv
hdl/writeback_select.sv
hdl/mem_wb_top.sv
verification/mem_wb_tb.sv

// File: verification/mem_wb_ref.svh
// reference model with shadow data memory, region copy and expected error and writeback functions
`ifndef MEM_WB_REF_SVH
`define MEM_WB_REF_SVH

logic [7:0] shadow_mem [4*TB_WORDS];
region_t    shadow_region;

function automatic int access_bytes(mem_width_e w);
    case (w)
        mem_byte: return 1;
        mem_half: return 2;
        default:  return 4;
    endcase
endfunction

// byte position in the shadow array, the address wraps onto the memory size
function automatic int byte_index(logic [31:0] addr, int i);
    return int'((addr + 32'(i)) % (4 * TB_WORDS));
endfunction

function automatic logic expected_error(mem_req_t r);
    logic misaligned;
    logic outside;
    misaligned = (r.width == mem_half && r.alu[0]) || (r.width == mem_word && r.alu[1:0] != 2'b00);
    outside = (r.alu < shadow_region.base) ||
              (64'(r.alu) + 64'(access_bytes(r.width)) > 64'(shadow_region.limit));
    return (r.rd_en || r.wr_en) && (misaligned || outside);
endfunction

function automatic logic [31:0] expected_load(mem_req_t r);
    logic [31:0] raw;
    int          n;
    if (!r.rd_en || expected_error(r)) begin
        return 32'd0;
    end
    raw = '0;
    n = access_bytes(r.width);
    for (int i = 0; i < n; i++) begin
        raw[i*8 +: 8] = shadow_mem[byte_index(r.alu, i)];
    end
    if (n == 1) begin
        return r.is_unsigned ? {24'd0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
    end
    if (n == 2) begin
        return r.is_unsigned ? {16'd0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
    end
    return raw;
endfunction

function automatic reg_write_t expected_write(mem_req_t r);
    reg_write_t w;
    w.en   = r.reg_wr_en && (r.rd_addr != 5'd0);
    w.addr = r.rd_addr;
    case (r.wb_sel)
        wb_mem:      w.data = expected_load(r);
        wb_pc_plus4: w.data = r.pc + 32'd4;
        default:     w.data = r.alu;
    endcase
    return w;
endfunction

function automatic void apply_store(mem_req_t r);
    if (r.wr_en && !expected_error(r)) begin
        for (int i = 0; i < access_bytes(r.width); i++) begin
            shadow_mem[byte_index(r.alu, i)] = r.store_data[i*8 +: 8];
        end
    end
endfunction

`endif

// File: verification/mem_wb_tb.sv
// testbench for the memory and writeback stages with reference checking and watchdog
`timescale 1ns/1ps

module mem_wb_tb
    import mem_pkg::*;
;
    localparam int TB_WORDS     = 256;
    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_STALL    = 2;
    localparam int RANDOM_REQS  = 300;
    // fill and full read sweep, directed cases, random stream and a margin
    localparam int TIMEOUT_NS = (RESET_CYCLES + 2 * TB_WORDS + 120 +
                                 RANDOM_REQS * (MAX_STALL + 1) + 40) * PERIOD;

    // what one presented cycle is expected to produce
    typedef struct packed {
        logic        err;
        logic        stall;
        reg_write_t  rf;
        logic [31:0] instr;
    } cycle_exp_t;

    logic        clk;
    logic        rst_n;
    logic        stall;
    mem_req_t    req;
    logic [31:0] instruction;
    logic        cfg_wr_en;
    logic        cfg_sel;
    logic [31:0] cfg_wdata;
    logic        mem_error;
    reg_write_t  rf_write;
    logic [31:0] instruction_out;

    cycle_exp_t  expect_q [$];
    cycle_exp_t  prev;
    logic        prev_valid = 1'b0;
    reg_write_t  held_rf = '0;
    logic [31:0] held_instr = '0;

    `include "mem_wb_ref.svh"

    mem_wb_top #(
        .DMEM_WORDS (TB_WORDS)
    ) u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .req             (req),
        .instruction     (instruction),
        .cfg_wr_en       (cfg_wr_en),
        .cfg_sel         (cfg_sel),
        .cfg_wdata       (cfg_wdata),
        .mem_error       (mem_error),
        .rf_write        (rf_write),
        .instruction_out (instruction_out)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_bit(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_word(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_reg_write(string name, reg_write_t actual, reg_write_t expected);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected en=%b addr=%0d data=%h actual en=%b addr=%0d data=%h",
                     $time, name, expected.en, expected.addr, expected.data,
                     actual.en, actual.addr, actual.data);
            abort_run();
        end
    endtask

    function automatic mem_req_t build_request(logic rd, logic wr, logic uns, mem_width_e w,
                                               logic reg_wr, wb_sel_e sel, logic [4:0] rd_addr,
                                               logic [31:0] addr, logic [31:0] data);
        mem_req_t r;
        r.rd_en       = rd;
        r.wr_en       = wr;
        r.is_unsigned = uns;
        r.width       = w;
        r.reg_wr_en   = reg_wr;
        r.wb_sel      = sel;
        r.rd_addr     = rd_addr;
        r.pc          = $urandom() & 32'hffff_fffc;
        r.alu         = addr;
        r.store_data  = data;
        return r;
    endfunction

    // one clock of stimulus where the expectation is taken before the store reaches the shadow
    task automatic drive_cycle(mem_req_t r, logic [31:0] instr, logic s,
                               logic cfg_en, logic sel, logic [31:0] data);
        cycle_exp_t e;
        @(posedge clk);
        req         <= r;
        instruction <= instr;
        stall       <= s;
        cfg_wr_en   <= cfg_en;
        cfg_sel     <= sel;
        cfg_wdata   <= data;
        e.err   = expected_error(r);
        e.stall = s;
        e.rf    = expected_write(r);
        e.instr = instr;
        expect_q.push_back(e);
        apply_store(r);
        if (cfg_en && sel) begin
            shadow_region.limit = data;
        end else if (cfg_en) begin
            shadow_region.base = data;
        end
    endtask

    // a stalled request is presented again until the stall drops
    task automatic present_request(mem_req_t r, int stalls);
        logic [31:0] instr;
        instr = $urandom();
        repeat (stalls) drive_cycle(r, instr, 1'b1, 1'b0, 1'b0, 32'd0);
        drive_cycle(r, instr, 1'b0, 1'b0, 1'b0, 32'd0);
    endtask

    task automatic write_region(logic sel, logic [31:0] value);
        drive_cycle('0, 32'd0, 1'b0, 1'b1, sel, value);
    endtask

    task automatic load_from(logic [31:0] addr, mem_width_e w, logic uns);
        present_request(build_request(1'b1, 1'b0, uns, w, 1'b1, wb_mem,
                                      5'($urandom_range(1, 31)), addr, $urandom()), 0);
    endtask

    task automatic store_to(logic [31:0] addr, mem_width_e w, logic [31:0] data);
        present_request(build_request(1'b0, 1'b1, 1'b0, w, 1'b0, wb_alu, 5'd0, addr, data), 0);
    endtask

    task automatic random_stream(int count);
        mem_req_t    r;
        mem_width_e  w;
        logic [31:0] addr;
        for (int n = 0; n < count; n++) begin
            w = mem_width_e'($urandom_range(0, 2));
            addr = $urandom_range(0, 32'h900);
            // most accesses are aligned and the rest probe the misalignment check
            if ($urandom_range(0, 3) != 0) begin
                addr = addr & ~(32'(access_bytes(w)) - 32'd1);
            end
            case ($urandom_range(0, 2))
                0: r = build_request(1'b1, 1'b0, 1'($urandom()), w, 1'b1, wb_mem,
                                     5'($urandom()), addr, $urandom());
                1: r = build_request(1'b0, 1'b1, 1'b0, w, 1'b0, wb_alu, 5'd0, addr, $urandom());
                default: r = build_request(1'b0, 1'b0, 1'b0, w, 1'($urandom()),
                                           wb_sel_e'($urandom_range(0, 1) ? wb_alu : wb_pc_plus4),
                                           5'($urandom()), $urandom(), 32'd0);
            endcase
            present_request(r, $urandom_range(0, MAX_STALL));
        end
    endtask

    // rf_write follows the last request that passed an unstalled edge
    always @(negedge clk) begin
        cycle_exp_t e;
        if (expect_q.size() > 0) begin
            e = expect_q.pop_front();
            if (prev_valid && !prev.stall) begin
                held_rf    = prev.rf;
                held_instr = prev.instr;
            end
            compare_bit("mem_error", mem_error, e.err);
            compare_reg_write("rf_write", rf_write, held_rf);
            compare_word("instruction_out", instruction_out, held_instr);
            prev       = e;
            prev_valid = 1'b1;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: the run did not finish within %0d ns", TIMEOUT_NS);
        abort_run();
    end

    initial begin
        void'($urandom(32'h8652));
        rst_n       = 1'b0;
        stall       = 1'b0;
        req         = '0;
        instruction = '0;
        cfg_wr_en   = 1'b0;
        cfg_sel     = 1'b0;
        cfg_wdata   = '0;
        shadow_region.base  = 32'd0;
        shadow_region.limit = 32'(4 * TB_WORDS);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_reg_write("rf_write", rf_write, '0);
        compare_word("instruction_out", instruction_out, 32'd0);

        // fill every word with an address-dependent pattern and read it all back
        for (int a = 0; a < 4 * TB_WORDS; a += 4) begin
            store_to(32'(a), mem_word, {~16'(a), 16'(a)} ^ 32'h5a3c_96e1);
        end
        for (int a = 0; a < 4 * TB_WORDS; a += 4) begin
            load_from(32'(a), mem_word, 1'b0);
        end

        store_to(32'h100, mem_byte, 32'h0000_0080);
        store_to(32'h101, mem_byte, 32'hffff_ff7f);
        store_to(32'h102, mem_half, 32'h1234_8123);
        store_to(32'h104, mem_word, 32'hf00d_beef);
        store_to(32'h108, mem_half, 32'h0000_7ffe);
        for (int off = 0; off < 12; off++) begin
            load_from(32'h100 + off, mem_byte, 1'b0);
            load_from(32'h100 + off, mem_byte, 1'b1);
        end
        for (int off = 0; off < 12; off += 2) begin
            load_from(32'h100 + off, mem_half, 1'b0);
            load_from(32'h100 + off, mem_half, 1'b1);
        end
        for (int off = 0; off < 12; off += 4) begin
            load_from(32'h100 + off, mem_word, 1'b0);
        end

        // misaligned stores must leave memory alone and misaligned loads return zero
        store_to(32'h101, mem_half, 32'h0000_aaaa);
        store_to(32'h106, mem_word, 32'h5555_5555);
        load_from(32'h100, mem_word, 1'b0);
        load_from(32'h104, mem_word, 1'b0);
        load_from(32'h103, mem_half, 1'b0);
        load_from(32'h102, mem_word, 1'b1);

        write_region(1'b0, 32'h200);
        write_region(1'b1, 32'h300);
        load_from(32'h1fc, mem_word, 1'b0);
        load_from(32'h1fe, mem_half, 1'b1);
        store_to(32'h300, mem_word, 32'hdead_0001);
        load_from(32'h300, mem_byte, 1'b0);
        store_to(32'h2fc, mem_word, 32'hc0de_cafe);
        load_from(32'h2fc, mem_word, 1'b0);
        store_to(32'h200, mem_byte, 32'h0000_00c5);
        load_from(32'h200, mem_byte, 1'b0);
        write_region(1'b0, 32'h000);
        write_region(1'b1, 32'h800);
        load_from(32'h300, mem_word, 1'b0);
        store_to(32'h404, mem_word, 32'h1357_9bdf);
        load_from(32'h004, mem_word, 1'b0);

        present_request(build_request(1'b0, 1'b0, 1'b0, mem_word, 1'b1, wb_alu, 5'd7,
                                      $urandom(), 32'd0), 0);
        present_request(build_request(1'b0, 1'b0, 1'b0, mem_word, 1'b1, wb_pc_plus4, 5'd9,
                                      $urandom(), 32'd0), 0);
        present_request(build_request(1'b0, 1'b0, 1'b0, mem_word, 1'b1, wb_alu, 5'd0,
                                      $urandom(), 32'd0), 0);
        present_request(build_request(1'b0, 1'b0, 1'b0, mem_word, 1'b0, wb_pc_plus4, 5'd12,
                                      $urandom(), 32'd0), 0);

        write_region(1'b0, 32'h010);
        random_stream(RANDOM_REQS);
        present_request('0, 0);
        present_request('0, 0);
        repeat (2) @(posedge clk);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: hdl/mem_wb_top.sv
// top level joining region configuration, memory stage and writeback stage
`timescale 1ns/1ps

module mem_wb_top
    import mem_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  mem_req_t    req,
    input  logic [31:0] instruction,
    input  logic        cfg_wr_en,
    input  logic        cfg_sel,
    input  logic [31:0] cfg_wdata,
    output logic        mem_error,
    output reg_write_t  rf_write,
    output logic [31:0] instruction_out
);

    region_t     region;
    mem_wb_t     mem_wb;
    logic [31:0] instruction_wb;

    mem_region_cfg #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_region_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr_en (cfg_wr_en),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .region    (region)
    );

    memory #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .req            (req),
        .instruction    (instruction),
        .region         (region),
        .mem_error      (mem_error),
        .mem_wb         (mem_wb),
        .instruction_wb (instruction_wb)
    );

    writeback_select u_writeback (
        .mem_wb          (mem_wb),
        .instruction_wb  (instruction_wb),
        .rf_write        (rf_write),
        .instruction_out (instruction_out)
    );

endmodule

// File: hdl/writeback_select.sv
// writeback stage with result selection and register-file write gating
`timescale 1ns/1ps

module writeback_select
    import mem_pkg::*;
(
    input  mem_wb_t     mem_wb,
    input  logic [31:0] instruction_wb,
    output reg_write_t  rf_write,
    output logic [31:0] instruction_out
);

    always_comb begin
        case (mem_wb.wb_sel)
            wb_mem:      rf_write.data = mem_wb.read_data;
            wb_pc_plus4: rf_write.data = mem_wb.pc + 32'd4;
            default:     rf_write.data = mem_wb.alu;
        endcase
    end

    // x0 is hardwired to zero so a write to it is dropped here
    assign rf_write.en   = mem_wb.reg_wr_en && (mem_wb.rd_addr != 5'd0);
    assign rf_write.addr = mem_wb.rd_addr;

    assign instruction_out = instruction_wb;

endmodule

// File: hdl/memory.sv
// memory pipeline stage with data memory access and the MEM/WB pipeline register
`timescale 1ns/1ps

module memory
    import mem_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  mem_req_t    req,
    input  logic [31:0] instruction,
    input  region_t     region,
    output logic        mem_error,
    output mem_wb_t     mem_wb,
    output logic [31:0] instruction_wb
);

    logic [31:0] load_data;

    data_memory_wrapper #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_en       (req.rd_en),
        .wr_en       (req.wr_en),
        .is_unsigned (req.is_unsigned),
        .width       (req.width),
        .addr        (req.alu),
        .store_data  (req.store_data),
        .region      (region),
        .rd_data     (load_data),
        .mem_error   (mem_error)
    );

    // a stall freezes the register while the same request is presented again
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb         <= '0;
            instruction_wb <= '0;
        end else if (!stall) begin
            mem_wb.reg_wr_en <= req.reg_wr_en;
            mem_wb.wb_sel    <= req.wb_sel;
            mem_wb.rd_addr   <= req.rd_addr;
            mem_wb.read_data <= load_data;
            mem_wb.pc        <= req.pc;
            mem_wb.alu       <= req.alu;
            instruction_wb   <= instruction;
        end
    end

endmodule

// File: hdl/data_memory_wrapper.sv
// load/store port with alignment, region bounds check, data RAM and load extraction
`timescale 1ns/1ps

module data_memory_wrapper
    import mem_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd_en,
    input  logic        wr_en,
    input  logic        is_unsigned,
    input  mem_width_e  width,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,
    input  region_t     region,
    output logic [31:0] rd_data,
    output logic        mem_error
);

    localparam int ADDR_W = $clog2(DMEM_WORDS);

    logic [31:0]       lane_data;
    logic [3:0]        byte_en;
    logic              misaligned;
    logic [32:0]       access_size;
    logic [32:0]       access_end;
    logic              out_of_region;
    logic [ADDR_W-1:0] word_addr;
    logic [31:0]       ram_rdata;
    logic [31:0]       load_data;

    store_align u_store_align (
        .addr       (addr),
        .width      (width),
        .store_data (store_data),
        .lane_data  (lane_data),
        .byte_en    (byte_en),
        .misaligned (misaligned)
    );

    always_comb begin
        case (width)
            mem_byte: access_size = 33'd1;
            mem_half: access_size = 33'd2;
            default:  access_size = 33'd4;
        endcase
    end

    // the end address is one bit wider so an access near the top of the space cannot wrap
    assign access_end    = {1'b0, addr} + access_size;
    assign out_of_region = (addr < region.base) || (access_end > {1'b0, region.limit});
    assign mem_error     = (rd_en || wr_en) && (misaligned || out_of_region);

    // addresses wrap onto the RAM depth by word index
    assign word_addr = addr[ADDR_W+1:2];

    data_ram #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_ram (
        .clk       (clk),
        .wr_en     (wr_en && !mem_error && rst_n),
        .byte_en   (byte_en),
        .word_addr (word_addr),
        .wdata     (lane_data),
        .rdata     (ram_rdata)
    );

    load_extract u_load_extract (
        .word        (ram_rdata),
        .byte_offset (addr[1:0]),
        .width       (width),
        .is_unsigned (is_unsigned),
        .data        (load_data)
    );

    // a faulting or absent load returns zero
    assign rd_data = (rd_en && !mem_error) ? load_data : '0;

endmodule

// File: hdl/data_ram.sv
// word-organised data RAM with byte-enabled write and asynchronous read
`timescale 1ns/1ps

module data_ram #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [3:0]                    byte_en,
    input  logic [$clog2(DMEM_WORDS)-1:0] word_addr,
    input  logic [31:0]                   wdata,
    output logic [31:0]                   rdata
);

    logic [31:0] mem [DMEM_WORDS];

    // each enabled lane is written on its own so partial stores keep the other bytes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_en[lane]) begin
                    mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

    // read is combinational so the load result is ready within the request cycle
    assign rdata = mem[word_addr];

endmodule

// File: hdl/load_extract.sv
// load byte/halfword selection with sign or zero extension
`timescale 1ns/1ps

module load_extract
    import mem_pkg::*;
(
    input  logic [31:0] word,
    input  logic [1:0]  byte_offset,
    input  mem_width_e  width,
    input  logic        is_unsigned,
    output logic [31:0] data
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;

    always_comb begin
        case (byte_offset)
            2'd0:    byte_val = word[7:0];
            2'd1:    byte_val = word[15:8];
            2'd2:    byte_val = word[23:16];
            default: byte_val = word[31:24];
        endcase
    end

    // only bit 1 matters here, an odd offset is already flagged as an error
    assign half_val = byte_offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (width)
            mem_byte: begin
                data = is_unsigned ? {24'd0, byte_val} : {{24{byte_val[7]}}, byte_val};
            end
            mem_half: begin
                data = is_unsigned ? {16'd0, half_val} : {{16{half_val[15]}}, half_val};
            end
            default: begin
                data = word;
            end
        endcase
    end

endmodule

// File: hdl/store_align.sv
// store lane steering, byte-enable generation and misalignment detection
`timescale 1ns/1ps

module store_align
    import mem_pkg::*;
(
    input  logic [31:0] addr,
    input  mem_width_e  width,
    input  logic [31:0] store_data,
    output logic [31:0] lane_data,
    output logic [3:0]  byte_en,
    output logic        misaligned
);

    logic [1:0] offset;

    assign offset = addr[1:0];

    // each width sets its own lanes, enables and alignment rule
    always_comb begin
        case (width)
            mem_byte: begin
                // the byte is copied to every lane so the enable alone picks the target
                lane_data  = {4{store_data[7:0]}};
                byte_en    = 4'b0001 << offset;
                misaligned = 1'b0;
            end
            mem_half: begin
                lane_data  = {2{store_data[15:0]}};
                byte_en    = offset[1] ? 4'b1100 : 4'b0011;
                misaligned = offset[0];
            end
            default: begin
                lane_data  = store_data;
                byte_en    = 4'b1111;
                misaligned = |offset;
            end
        endcase
    end

endmodule

// File: hdl/mem_region_cfg.sv
// configuration registers for the base and limit of the valid data region
`timescale 1ns/1ps

module mem_region_cfg
    import mem_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cfg_wr_en,
    input  logic        cfg_sel,
    input  logic [31:0] cfg_wdata,
    output region_t     region
);

    // size of the whole data memory in bytes
    localparam logic [31:0] DMEM_BYTES = 32'(DMEM_WORDS * 4);

    logic [31:0] base_q;
    logic [31:0] limit_q;

    // after reset the window covers the full memory
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            base_q <= '0;
        end else if (cfg_wr_en && !cfg_sel) begin
            base_q <= cfg_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            limit_q <= DMEM_BYTES;
        end else if (cfg_wr_en && cfg_sel) begin
            limit_q <= cfg_wdata;
        end
    end

    always_comb begin
        region.base  = base_q;
        region.limit = limit_q;
    end

endmodule

// File: hdl/mem_pkg.sv
// access width and writeback source enums, request, MEM/WB, region and register-write structs
package mem_pkg;

    // load/store access size, encoded as the low two bits of funct3
    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_width_e;

    // source of the value written back to the register file
    typedef enum logic [1:0] {
        wb_alu      = 2'd0,
        wb_mem      = 2'd1,
        wb_pc_plus4 = 2'd2
    } wb_sel_e;

    // one request handed from execute to the memory stage
    typedef struct packed {
        logic        rd_en;
        logic        wr_en;
        logic        is_unsigned;
        mem_width_e  width;
        logic        reg_wr_en;
        wb_sel_e     wb_sel;
        logic [4:0]  rd_addr;
        logic [31:0] pc;
        // the ALU result doubles as the load/store byte address
        logic [31:0] alu;
        logic [31:0] store_data;
    } mem_req_t;

    // state carried across the MEM/WB pipeline register
    typedef struct packed {
        logic        reg_wr_en;
        wb_sel_e     wb_sel;
        logic [4:0]  rd_addr;
        logic [31:0] read_data;
        logic [31:0] pc;
        logic [31:0] alu;
    } mem_wb_t;

    // valid data window in byte addresses, limit is exclusive
    typedef struct packed {
        logic [31:0] base;
        logic [31:0] limit;
    } region_t;

    // write request towards the register file
    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } reg_write_t;

endpackage
